// File: source/cpu_pkg.sv
package cpu_pkg;

	// ====================
	// Widths
	// ====================

	// Data, PC and instruction word
	typedef logic [15:0] word_t;
	// Register file index
	typedef logic [3:0]  reg_idx_t;
	// Opcode field, bits 15:12
	typedef logic [3:0]  op_t;
	// Branch condition, bits 11:9
	typedef logic [2:0]  cond_t;
	// Flags, N in bit 2, V in bit 1, Z in bit 0
	typedef logic [2:0]  nvz_t;
	// Word index into instruction or data memory
	typedef logic [7:0]  mem_addr_t;

	// ====================
	// Encodings
	// ====================

	localparam op_t OP_ADD = 4'h0;
	localparam op_t OP_SUB = 4'h1;
	localparam op_t OP_XOR = 4'h2;
	localparam op_t OP_LW  = 4'h8;
	localparam op_t OP_SW  = 4'h9;
	localparam op_t OP_LLB = 4'hA;
	localparam op_t OP_LHB = 4'hB;
	localparam op_t OP_B   = 4'hC;
	localparam op_t OP_HLT = 4'hF;

	// Condition codes
	localparam cond_t COND_NE = 3'b000;
	localparam cond_t COND_EQ = 3'b001;
	localparam cond_t COND_GT = 3'b010;
	localparam cond_t COND_LT = 3'b011;
	localparam cond_t COND_AL = 3'b111;

	// Both memories hold 256 words
	localparam int MEM_WORDS = 256;
	// Halt as written in a program
	localparam word_t HLT_WORD = 16'hF000;

endpackage

// File: source/fetch_stage.sv
module fetch_stage import cpu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      stall,
	input  logic      branch_taken,
	input  word_t     branch_target,
	input  logic      imem_we,
	input  mem_addr_t imem_addr,
	input  word_t     imem_wdata,
	output logic      fd_valid,
	output word_t     fd_instr,
	output word_t     fd_pc,
	output word_t     fd_pc_next
);

	word_t     pc_q;
	word_t     pc_d;
	word_t     pc_plus2;
	word_t     imem_rd;
	mem_addr_t fetch_idx;
	logic      fetch_hlt;

	// Instruction memory, word addressed
	word_t imem [MEM_WORDS];

	// Load port, driven while the core is held in reset
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	// Byte PC to word index, read is combinational
	assign fetch_idx = pc_q[8:1];
	assign imem_rd   = imem[fetch_idx];
	assign pc_plus2  = pc_q + 16'd2;
	// HLT in fetch freezes the PC
	assign fetch_hlt = (imem_rd[15:12] == OP_HLT);

	// Next PC, a taken branch wins over stall and halt
	always_comb begin
		if (branch_taken) begin
			pc_d = branch_target;
		end else if (stall || fetch_hlt) begin
			pc_d = pc_q;
		end else begin
			pc_d = pc_plus2;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_d;
		end
	end

	// ====================
	// Fetch/decode register
	// ====================

	// Flush clears valid, stall holds it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fd_valid <= 1'b0;
		end else if (branch_taken) begin
			fd_valid <= 1'b0;
		end else if (!stall) begin
			fd_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fd_instr   <= imem_rd;
			fd_pc      <= pc_q;
			fd_pc_next <= pc_plus2;
		end
	end

endmodule

// File: source/decode_stage.sv
module decode_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     fd_valid,
	input  word_t    fd_instr,
	input  word_t    fd_pc,
	input  word_t    fd_pc_next,
	input  logic     stall,
	input  logic     branch_taken,
	input  logic     wb_en,
	input  reg_idx_t wb_dest,
	input  word_t    wb_data,
	input  reg_idx_t dbg_sel,
	output word_t    dbg_data,
	output reg_idx_t src1,
	output reg_idx_t src2,
	output logic     dx_valid,
	output logic     dx_reg_we,
	output logic     dx_mem_rd,
	output logic     dx_mem_wr,
	output logic     dx_branch,
	output logic     dx_load_byte,
	output logic     dx_halt,
	output reg_idx_t dx_src1,
	output reg_idx_t dx_src2,
	output reg_idx_t dx_dest,
	output word_t    dx_a,
	output word_t    dx_b,
	output word_t    dx_imm,
	output word_t    dx_instr,
	output word_t    dx_pc,
	output word_t    dx_pc_next
);

	op_t      op;
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	reg_idx_t rd_idx;
	logic     reg_we;
	logic     mem_rd;
	logic     mem_wr;
	logic     is_branch;
	logic     load_byte;
	logic     is_hlt;
	logic     issue;
	word_t    imm;
	word_t    rd1;
	word_t    rd2;

	// Sixteen general registers
	word_t rf [16];

	assign op     = fd_instr[15:12];
	assign rd_idx = fd_instr[11:8];

	// ====================
	// Control decode
	// ====================

	always_comb begin
		reg_we    = 1'b0;
		mem_rd    = 1'b0;
		mem_wr    = 1'b0;
		is_branch = 1'b0;
		load_byte = 1'b0;
		is_hlt    = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_XOR: reg_we = 1'b1;
			OP_LW: begin
				reg_we = 1'b1;
				mem_rd = 1'b1;
			end
			OP_SW: mem_wr = 1'b1;
			OP_LLB, OP_LHB: begin
				reg_we    = 1'b1;
				load_byte = 1'b1;
			end
			OP_B:   is_branch = 1'b1;
			OP_HLT: is_hlt = 1'b1;
			// Unused opcodes fall through as no-ops
			default: reg_we = 1'b0;
		endcase
	end

	// LLB/LHB read rd to keep the other byte
	assign rs_idx = load_byte ? fd_instr[11:8] : fd_instr[7:4];
	// Store data sits in the rt slot at bits 11:8
	assign rt_idx = (mem_rd || mem_wr) ? fd_instr[11:8] : fd_instr[3:0];

	// Sources for the load-use check
	assign src1 = rs_idx;
	// Store data skips the check, memory stage forwards it
	assign src2 = (mem_rd || mem_wr || load_byte) ? rs_idx : rt_idx;

	// Immediate build
	always_comb begin
		if (mem_rd || mem_wr) begin
			// Offset in words, so shift left one
			imm = {{11{fd_instr[3]}}, fd_instr[3:0], 1'b0};
		end else if (load_byte) begin
			imm = (op == OP_LHB) ? {fd_instr[7:0], 8'h00} : {8'h00, fd_instr[7:0]};
		end else if (is_branch) begin
			imm = {{6{fd_instr[8]}}, fd_instr[8:0], 1'b0};
		end else begin
			imm = '0;
		end
	end

	// ====================
	// Register file
	// ====================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++) begin
				rf[i] <= '0;
			end
		end else if (wb_en) begin
			rf[wb_dest] <= wb_data;
		end
	end

	// Write-through from writeback in the same cycle
	assign rd1 = (wb_en && wb_dest == rs_idx) ? wb_data : rf[rs_idx];
	assign rd2 = (wb_en && wb_dest == rt_idx) ? wb_data : rf[rt_idx];

	// Inspection port
	assign dbg_data = rf[dbg_sel];

	// Bubble on stall or flush
	assign issue = fd_valid && !stall && !branch_taken;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dx_valid     <= 1'b0;
			dx_reg_we    <= 1'b0;
			dx_mem_rd    <= 1'b0;
			dx_mem_wr    <= 1'b0;
			dx_branch    <= 1'b0;
			dx_load_byte <= 1'b0;
			dx_halt      <= 1'b0;
		end else begin
			dx_valid     <= issue;
			dx_reg_we    <= issue && reg_we;
			dx_mem_rd    <= issue && mem_rd;
			dx_mem_wr    <= issue && mem_wr;
			dx_branch    <= issue && is_branch;
			dx_load_byte <= issue && load_byte;
			dx_halt      <= issue && is_hlt;
		end
	end

	always_ff @(posedge clk) begin
		dx_src1    <= rs_idx;
		dx_src2    <= rt_idx;
		dx_dest    <= rd_idx;
		dx_a       <= rd1;
		dx_b       <= rd2;
		dx_imm     <= imm;
		dx_instr   <= fd_instr;
		dx_pc      <= fd_pc;
		dx_pc_next <= fd_pc_next;
	end

endmodule

// File: source/hazard_unit.sv
module hazard_unit import cpu_pkg::*; (
	input  reg_idx_t         src1,
	input  reg_idx_t         src2,
	input  logic             dx_valid,
	input  logic             dx_mem_rd,
	input  reg_idx_t         dx_dest,
	input  reg_idx_t         dx_src1,
	input  reg_idx_t         dx_src2,
	input  logic             xm_valid,
	input  logic             xm_reg_we,
	input  logic             xm_mem_rd,
	input  reg_idx_t         xm_dest,
	input  reg_idx_t         xm_src2,
	input  logic             wb_en,
	input  reg_idx_t         wb_dest,
	output logic             stall,
	output logic       [1:0] fwd_a_sel,
	output logic       [1:0] fwd_b_sel,
	output logic             fwd_st
);

	logic load_in_ex;
	logic xm_fwd_ok;

	// Load in execute feeding decode costs one bubble
	assign load_in_ex = dx_valid && dx_mem_rd;
	assign stall      = load_in_ex && (dx_dest == src1 || dx_dest == src2);

	// ALU result in memory stage, load data is not ready there
	assign xm_fwd_ok = xm_valid && xm_reg_we && !xm_mem_rd;

	// Select 01 from memory stage, 10 from writeback, 00 register value
	always_comb begin
		fwd_a_sel = 2'b00;
		if (xm_fwd_ok && xm_dest == dx_src1) begin
			fwd_a_sel = 2'b01;
		end else if (wb_en && wb_dest == dx_src1) begin
			fwd_a_sel = 2'b10;
		end
	end

	always_comb begin
		fwd_b_sel = 2'b00;
		if (xm_fwd_ok && xm_dest == dx_src2) begin
			fwd_b_sel = 2'b01;
		end else if (wb_en && wb_dest == dx_src2) begin
			fwd_b_sel = 2'b10;
		end
	end

	// Store data from writeback, covers a load right before a store
	assign fwd_st = xm_valid && wb_en && (wb_dest == xm_src2);

endmodule

// File: source/execute_stage.sv
module execute_stage import cpu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       dx_valid,
	input  logic       dx_reg_we,
	input  logic       dx_mem_rd,
	input  logic       dx_mem_wr,
	input  logic       dx_branch,
	input  logic       dx_load_byte,
	input  logic       dx_halt,
	input  reg_idx_t   dx_src2,
	input  reg_idx_t   dx_dest,
	input  word_t      dx_a,
	input  word_t      dx_b,
	input  word_t      dx_imm,
	input  word_t      dx_instr,
	input  word_t      dx_pc,
	input  word_t      dx_pc_next,
	input  logic [1:0] fwd_a_sel,
	input  logic [1:0] fwd_b_sel,
	input  word_t      wb_data,
	output logic       branch_taken,
	output word_t      branch_target,
	output logic       xm_valid,
	output logic       xm_reg_we,
	output logic       xm_mem_rd,
	output logic       xm_mem_wr,
	output logic       xm_halt,
	output reg_idx_t   xm_dest,
	output reg_idx_t   xm_src2,
	output word_t      xm_result,
	output word_t      xm_store,
	output word_t      xm_pc
);

	word_t a_fwd;
	word_t b_fwd;
	word_t op_a;
	word_t op_b;
	word_t alu_res;
	op_t   ex_op;
	op_t   alu_op;
	logic  use_imm;
	logic  add_ovf;
	logic  sub_ovf;
	logic  res_zero;
	nvz_t  flags;
	cond_t cond;
	logic  cond_met;

	// ====================
	// Operand forwarding
	// ====================

	always_comb begin
		case (fwd_a_sel)
			2'b01:   a_fwd = xm_result;
			2'b10:   a_fwd = wb_data;
			default: a_fwd = dx_a;
		endcase
	end

	always_comb begin
		case (fwd_b_sel)
			2'b01:   b_fwd = xm_result;
			2'b10:   b_fwd = wb_data;
			default: b_fwd = dx_b;
		endcase
	end

	assign ex_op   = dx_instr[15:12];
	assign use_imm = dx_mem_rd || dx_mem_wr || dx_load_byte;

	// Word-align addresses, clear the byte that LLB/LHB replaces
	always_comb begin
		if (dx_mem_rd || dx_mem_wr) begin
			op_a = a_fwd & 16'hFFFE;
		end else if (dx_load_byte) begin
			op_a = (ex_op == OP_LHB) ? (a_fwd & 16'h00FF) : (a_fwd & 16'hFF00);
		end else begin
			op_a = a_fwd;
		end
	end

	assign op_b   = use_imm ? dx_imm : b_fwd;
	// Address and byte loads are plain adds
	assign alu_op = use_imm ? OP_ADD : ex_op;

	// ALU, wrapping two's complement
	always_comb begin
		case (alu_op)
			OP_SUB:  alu_res = op_a - op_b;
			OP_XOR:  alu_res = op_a ^ op_b;
			default: alu_res = op_a + op_b;
		endcase
	end

	// Signed overflow when the sign flips against the operands
	assign add_ovf  = (op_a[15] == op_b[15]) && (alu_res[15] != op_a[15]);
	assign sub_ovf  = (op_a[15] != op_b[15]) && (alu_res[15] != op_a[15]);
	assign res_zero = (alu_res == 16'h0000);

	// Flag register, XOR only touches Z
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (dx_valid) begin
			case (ex_op)
				OP_ADD:  flags <= {alu_res[15], add_ovf, res_zero};
				OP_SUB:  flags <= {alu_res[15], sub_ovf, res_zero};
				OP_XOR:  flags[0] <= res_zero;
				default: flags <= flags;
			endcase
		end
	end

	// ====================
	// Branch resolve
	// ====================

	assign cond = dx_instr[11:9];

	always_comb begin
		case (cond)
			COND_NE: cond_met = !flags[0];
			COND_EQ: cond_met = flags[0];
			COND_GT: cond_met = !flags[0] && !flags[2];
			COND_LT: cond_met = flags[2];
			COND_AL: cond_met = 1'b1;
			default: cond_met = 1'b0;
		endcase
	end

	assign branch_taken  = dx_valid && dx_branch && cond_met;
	// PC+2 plus the word offset
	assign branch_target = dx_pc_next + dx_imm;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			xm_valid  <= 1'b0;
			xm_reg_we <= 1'b0;
			xm_mem_rd <= 1'b0;
			xm_mem_wr <= 1'b0;
			xm_halt   <= 1'b0;
		end else begin
			xm_valid  <= dx_valid;
			xm_reg_we <= dx_valid && dx_reg_we;
			xm_mem_rd <= dx_valid && dx_mem_rd;
			xm_mem_wr <= dx_valid && dx_mem_wr;
			xm_halt   <= dx_valid && dx_halt;
		end
	end

	always_ff @(posedge clk) begin
		xm_dest   <= dx_dest;
		xm_src2   <= dx_src2;
		xm_result <= alu_res;
		xm_store  <= b_fwd;
		xm_pc     <= dx_pc;
	end

endmodule

// File: source/memory_stage.sv
module memory_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     xm_valid,
	input  logic     xm_reg_we,
	input  logic     xm_mem_rd,
	input  logic     xm_mem_wr,
	input  logic     xm_halt,
	input  reg_idx_t xm_dest,
	input  word_t    xm_result,
	input  word_t    xm_store,
	input  word_t    xm_pc,
	input  logic     fwd_st,
	output logic     mw_valid,
	output logic     wb_en,
	output reg_idx_t wb_dest,
	output word_t    wb_data,
	output word_t    mw_pc,
	output logic     mw_halt
);

	mem_addr_t dmem_idx;
	word_t     st_data;
	word_t     dmem_rd;

	// Data memory, word addressed
	word_t dmem [MEM_WORDS];

	assign dmem_idx = xm_result[8:1];
	assign dmem_rd  = dmem[dmem_idx];

	// Load result sitting in writeback feeds a store right behind it
	assign st_data = fwd_st ? wb_data : xm_store;

	always_ff @(posedge clk) begin
		if (xm_valid && xm_mem_wr) begin
			dmem[dmem_idx] <= st_data;
		end
	end

	// ====================
	// Memory/writeback register
	// ====================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mw_valid <= 1'b0;
			wb_en    <= 1'b0;
			mw_halt  <= 1'b0;
			mw_pc    <= '0;
		end else begin
			mw_valid <= xm_valid;
			wb_en    <= xm_valid && xm_reg_we;
			// Sticky until reset
			mw_halt  <= mw_halt || (xm_valid && xm_halt);
			// Hold the HLT address once halted
			if (xm_valid && !mw_halt) begin
				mw_pc <= xm_pc;
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_dest <= xm_dest;
		wb_data <= xm_mem_rd ? dmem_rd : xm_result;
	end

endmodule

// File: source/cpu_top.sv
module cpu_top import cpu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  logic      imem_we,
	input  mem_addr_t imem_addr,
	input  word_t     imem_wdata,
	input  reg_idx_t  dbg_sel,
	output word_t     dbg_data,
	output logic      hlt,
	output word_t     pc
);

	// Fetch/decode
	logic     fd_valid;
	word_t    fd_instr;
	word_t    fd_pc;
	word_t    fd_pc_next;

	// Decode/execute
	reg_idx_t src1;
	reg_idx_t src2;
	logic     dx_valid;
	logic     dx_reg_we;
	logic     dx_mem_rd;
	logic     dx_mem_wr;
	logic     dx_branch;
	logic     dx_load_byte;
	logic     dx_halt;
	reg_idx_t dx_src1;
	reg_idx_t dx_src2;
	reg_idx_t dx_dest;
	word_t    dx_a;
	word_t    dx_b;
	word_t    dx_imm;
	word_t    dx_instr;
	word_t    dx_pc;
	word_t    dx_pc_next;

	// Hazard and branch control
	logic       stall;
	logic [1:0] fwd_a_sel;
	logic [1:0] fwd_b_sel;
	logic       fwd_st;
	logic       branch_taken;
	word_t      branch_target;

	// Execute/memory
	logic     xm_valid;
	logic     xm_reg_we;
	logic     xm_mem_rd;
	logic     xm_mem_wr;
	logic     xm_halt;
	reg_idx_t xm_dest;
	reg_idx_t xm_src2;
	word_t    xm_result;
	word_t    xm_store;
	word_t    xm_pc;

	// Memory/writeback
	logic     wb_en;
	reg_idx_t wb_dest;
	word_t    wb_data;

	// Stages connect by matching names
	fetch_stage u_fetch (.*);

	decode_stage u_decode (.*);

	hazard_unit u_hazard (.*);

	execute_stage u_execute (.*);

	// Halt and PC come straight from writeback
	memory_stage u_memory (
		.mw_valid (),
		.mw_halt  (hlt),
		.mw_pc    (pc),
		.*
	);

endmodule

// File: tb/cpu_checker.sv
module cpu_checker import cpu_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  hlt,
	input  word_t pc,
	input  logic  stall,
	input  logic  dx_valid,
	input  logic  xm_valid,
	input  logic  xm_mem_rd,
	input  logic  branch_taken
);

	// ====================
	// Halt
	// ====================

	// Once raised, hlt holds until the next reset and pc stays on the HLT
	hlt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		hlt |=> (hlt && $stable(pc)))
		else $error("hlt dropped or pc moved while out of reset");

	// Halt address is a word address
	hlt_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) hlt |-> !pc[0])
		else $error("pc odd while halted");

	// ====================
	// Pipeline control
	// ====================

	// Stall means a valid load in execute, it moves on behind a bubble
	stall_on_load: assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> (xm_valid && xm_mem_rd && !dx_valid))
		else $error("stall without a valid load in execute");

	// Execute is empty right after reset
	no_early_branch: assert property (@(posedge clk) $rose(arst_n) |-> !branch_taken)
		else $error("branch taken in first cycle after reset");

endmodule

bind cpu_top cpu_checker u_checker (
	.clk          (clk),
	.arst_n       (arst_n),
	.hlt          (hlt),
	.pc           (pc),
	.stall        (stall),
	.dx_valid     (dx_valid),
	.xm_valid     (xm_valid),
	.xm_mem_rd    (xm_mem_rd),
	.branch_taken (branch_taken)
);

// File: tb/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

	localparam int NUM_TESTS  = 5;
	localparam int PROG_WORDS = 16;
	localparam int NUM_CHECKS = 4;
	localparam int HALT_LIMIT = 60;
	localparam int CLK_PERIOD = 40;

	logic      clk = 1'b0;
	logic      arst_n;
	logic      imem_we;
	mem_addr_t imem_addr;
	word_t     imem_wdata;
	reg_idx_t  dbg_sel;
	word_t     dbg_data;
	logic      hlt;
	word_t     pc;

	// Test table, one program and four expected registers per test
	word_t    prog      [NUM_TESTS][PROG_WORDS];
	word_t    halt_pc   [NUM_TESTS];
	reg_idx_t chk_reg   [NUM_TESTS][NUM_CHECKS];
	word_t    chk_val   [NUM_TESTS][NUM_CHECKS];
	string    test_name [NUM_TESTS];

	integer seed;
	int     err_count;
	int     check_count;
	int     fail_tests;

	cpu_top u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.dbg_sel    (dbg_sel),
		.dbg_data   (dbg_data),
		.hlt        (hlt),
		.pc         (pc)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ====================
	// Assembler helpers
	// ====================

	// rd, rs, rt
	function automatic word_t alu_word(op_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
		return {op, rd, rs, rt};
	endfunction

	// rt, rs, signed word offset
	function automatic word_t ldst_word(op_t op, reg_idx_t rt, reg_idx_t rs, logic [3:0] off);
		return {op, rt, rs, off};
	endfunction

	function automatic word_t byte_word(op_t op, reg_idx_t rd, logic [7:0] imm8);
		return {op, rd, imm8};
	endfunction

	// Offset counted in words from PC+2
	function automatic word_t branch_word(cond_t cond, logic [8:0] off);
		return {OP_B, cond, off};
	endfunction

	task automatic add_check(input int t, input int k, input reg_idx_t r, input word_t v);
		chk_reg[t][k] = r;
		chk_val[t][k] = v;
	endtask

	// ====================
	// Test programs
	// ====================

	// Back-to-back ALU chain, hits every forward path
	task automatic arith_chain_prog();
		word_t r1;
		word_t r2;
		word_t r3;
		word_t r4;
		word_t r5;
		word_t r6;
		word_t r7;
		r1 = 16'h8005;
		r2 = 16'h00F0;
		r3 = r1 + r2;
		r4 = r3 - r1;
		r5 = r4 ^ r3;
		r6 = r5 + r5;
		r7 = r2 - r6;
		test_name[0] = "arith_chain";
		prog[0][0] = byte_word(OP_LLB, 4'd1, 8'h05);
		prog[0][1] = byte_word(OP_LHB, 4'd1, 8'h80);
		prog[0][2] = byte_word(OP_LLB, 4'd2, 8'hF0);
		prog[0][3] = alu_word(OP_ADD, 4'd3, 4'd1, 4'd2);
		prog[0][4] = alu_word(OP_SUB, 4'd4, 4'd3, 4'd1);
		prog[0][5] = alu_word(OP_XOR, 4'd5, 4'd4, 4'd3);
		prog[0][6] = alu_word(OP_ADD, 4'd6, 4'd5, 4'd5);
		prog[0][7] = alu_word(OP_SUB, 4'd7, 4'd2, 4'd6);
		prog[0][8] = HLT_WORD;
		halt_pc[0] = 16'h0010;
		add_check(0, 0, 4'd3, r3);
		add_check(0, 1, 4'd5, r5);
		add_check(0, 2, 4'd6, r6);
		add_check(0, 3, 4'd7, r7);
	endtask

	// Second base r8 reaches the same words with other offsets
	task automatic store_load_prog();
		word_t r1;
		r1 = 16'h1234;
		test_name[1] = "store_load";
		prog[1][0]  = byte_word(OP_LLB, 4'd1, 8'h34);
		prog[1][1]  = byte_word(OP_LHB, 4'd1, 8'h12);
		// Odd base, bit 0 is dropped from the address
		prog[1][2]  = byte_word(OP_LLB, 4'd2, 8'h21);
		prog[1][3]  = byte_word(OP_LLB, 4'd8, 8'h26);
		// Byte address 0x24 from both bases
		prog[1][4]  = ldst_word(OP_SW, 4'd1, 4'd2, 4'h2);
		prog[1][5]  = ldst_word(OP_LW, 4'd3, 4'd8, 4'hF);
		// Load-use stall
		prog[1][6]  = alu_word(OP_ADD, 4'd4, 4'd3, 4'd1);
		prog[1][7]  = ldst_word(OP_LW, 4'd5, 4'd2, 4'h2);
		// Store data comes from the load right before it, byte address 0x1E
		prog[1][8]  = ldst_word(OP_SW, 4'd5, 4'd2, 4'hF);
		prog[1][9]  = ldst_word(OP_LW, 4'd6, 4'd8, 4'hC);
		prog[1][10] = alu_word(OP_ADD, 4'd7, 4'd6, 4'd6);
		prog[1][11] = HLT_WORD;
		halt_pc[1] = 16'h0016;
		add_check(1, 0, 4'd3, r1);
		add_check(1, 1, 4'd4, r1 + r1);
		add_check(1, 2, 4'd6, r1);
		add_check(1, 3, 4'd7, r1 + r1);
	endtask

	// Skipped slots all write r10, fall-throughs write r11 and r12
	task automatic branch_prog();
		word_t diff;
		diff = 16'd3 - 16'd5;
		test_name[2] = "branches";
		prog[2][0]  = byte_word(OP_LLB, 4'd1, 8'h03);
		prog[2][1]  = byte_word(OP_LLB, 4'd2, 8'h05);
		prog[2][2]  = alu_word(OP_SUB, 4'd3, 4'd1, 4'd2);
		prog[2][3]  = branch_word(COND_LT, 9'd1);
		prog[2][4]  = byte_word(OP_LLB, 4'd10, 8'h11);
		prog[2][5]  = branch_word(COND_EQ, 9'd1);
		prog[2][6]  = byte_word(OP_LLB, 4'd11, 8'h22);
		prog[2][7]  = alu_word(OP_SUB, 4'd4, 4'd2, 4'd1);
		prog[2][8]  = branch_word(COND_GT, 9'd1);
		prog[2][9]  = byte_word(OP_LLB, 4'd10, 8'h33);
		// Zero result, N left clear
		prog[2][10] = alu_word(OP_XOR, 4'd5, 4'd1, 4'd1);
		prog[2][11] = branch_word(COND_NE, 9'd1);
		prog[2][12] = byte_word(OP_LLB, 4'd12, 8'h44);
		prog[2][13] = branch_word(COND_AL, 9'd1);
		prog[2][14] = byte_word(OP_LLB, 4'd10, 8'h55);
		prog[2][15] = HLT_WORD;
		halt_pc[2] = 16'h001E;
		add_check(2, 0, 4'd10, 16'h0000);
		add_check(2, 1, 4'd11, 16'h0022);
		add_check(2, 2, 4'd12, 16'h0044);
		add_check(2, 3, 4'd3, diff);
	endtask

	// Words after HLT must never retire
	task automatic halt_prog();
		test_name[3] = "halt";
		prog[3][0] = byte_word(OP_LLB, 4'd1, 8'h0A);
		prog[3][1] = byte_word(OP_LLB, 4'd2, 8'h07);
		prog[3][2] = alu_word(OP_ADD, 4'd3, 4'd1, 4'd2);
		prog[3][3] = HLT_WORD;
		prog[3][4] = byte_word(OP_LLB, 4'd1, 8'hFF);
		prog[3][5] = alu_word(OP_ADD, 4'd3, 4'd3, 4'd3);
		prog[3][6] = byte_word(OP_LLB, 4'd4, 8'h99);
		halt_pc[3] = 16'h0006;
		add_check(3, 0, 4'd1, 16'h000A);
		add_check(3, 1, 4'd2, 16'h0007);
		add_check(3, 2, 4'd3, 16'h0011);
		add_check(3, 3, 4'd4, 16'h0000);
	endtask

	task automatic random_ops_prog();
		word_t ra;
		word_t rb;
		ra = word_t'($random(seed));
		rb = word_t'($random(seed));
		test_name[4] = "random_ops";
		prog[4][0] = byte_word(OP_LLB, 4'd1, ra[7:0]);
		prog[4][1] = byte_word(OP_LHB, 4'd1, ra[15:8]);
		prog[4][2] = byte_word(OP_LLB, 4'd2, rb[7:0]);
		prog[4][3] = byte_word(OP_LHB, 4'd2, rb[15:8]);
		prog[4][4] = alu_word(OP_ADD, 4'd3, 4'd1, 4'd2);
		prog[4][5] = alu_word(OP_SUB, 4'd4, 4'd1, 4'd2);
		prog[4][6] = alu_word(OP_XOR, 4'd5, 4'd1, 4'd2);
		prog[4][7] = HLT_WORD;
		halt_pc[4] = 16'h000E;
		add_check(4, 0, 4'd1, ra);
		add_check(4, 1, 4'd3, ra + rb);
		add_check(4, 2, 4'd4, ra - rb);
		add_check(4, 3, 4'd5, ra ^ rb);
	endtask

	task automatic fill_test_table();
		// Unused slots hold HLT
		for (int t = 0; t < NUM_TESTS; t++) begin
			for (int i = 0; i < PROG_WORDS; i++) begin
				prog[t][i] = HLT_WORD;
			end
		end
		arith_chain_prog();
		store_load_prog();
		branch_prog();
		halt_prog();
		random_ops_prog();
	endtask

	// ====================
	// Run helpers
	// ====================

	// Reset, then load the program with the core still held
	task automatic reset_and_load(input int t);
		@(posedge clk);
		#5;
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		#5;
		for (int i = 0; i < PROG_WORDS; i++) begin
			imem_we    = 1'b1;
			imem_addr  = mem_addr_t'(i);
			imem_wdata = prog[t][i];
			@(posedge clk);
			#5;
		end
		imem_we = 1'b0;
		arst_n  = 1'b1;
	endtask

	task automatic wait_for_halt(output bit seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < HALT_LIMIT) begin
			@(negedge clk);
			if (hlt) begin
				seen = 1'b1;
			end
			n++;
		end
	endtask

	// PC first, then one register per cycle through the debug port
	task automatic check_results(input int t);
		check_count++;
		if (pc !== halt_pc[t]) begin
			$display("[FAIL] pc exp %h got %h (test %0d)", halt_pc[t], pc, t + 1);
			err_count++;
		end
		for (int k = 0; k < NUM_CHECKS; k++) begin
			@(posedge clk);
			#5;
			dbg_sel = chk_reg[t][k];
			@(negedge clk);
			check_count++;
			if (dbg_data !== chk_val[t][k]) begin
				$display("[FAIL] dbg_data r%0d exp %h got %h (test %0d)",
					chk_reg[t][k], chk_val[t][k], dbg_data, t + 1);
				err_count++;
			end
		end
	endtask

	task automatic run_test(input int t);
		bit seen;
		int errs_before;
		errs_before = err_count;
		reset_and_load(t);
		wait_for_halt(seen);
		if (!seen) begin
			$display("test %0d %s: hlt never rose within %0d cycles",
				t + 1, test_name[t], HALT_LIMIT);
			err_count++;
		end else begin
			check_results(t);
		end
		if (err_count == errs_before) begin
			$display("test %0d %s: ok", t + 1, test_name[t]);
		end else begin
			fail_tests++;
			$display("test %0d %s: %0d errors", t + 1, test_name[t], err_count - errs_before);
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin : main
		seed        = 32'haf03_27f8;
		arst_n      = 1'b0;
		imem_we     = 1'b0;
		imem_addr   = '0;
		imem_wdata  = '0;
		dbg_sel     = '0;
		err_count   = 0;
		check_count = 0;
		fail_tests  = 0;
		fill_test_table();
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(t);
		end
		$display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
			NUM_TESTS, NUM_TESTS - fail_tests, fail_tests, check_count, err_count);
		if (err_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// About 100 cycles per test
	initial begin : watchdog
		#(NUM_TESTS * 100 * CLK_PERIOD);
		$display("watchdog expired after %0d time units", NUM_TESTS * 100 * CLK_PERIOD);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: files.f
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/hazard_unit.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu_top.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the cpu testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -f files.f; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vcpu_tb 2>&1)
sim_rc=$?
printf '%s\n' "$sim_out"

if [ "$sim_rc" -ne 0 ]; then
	echo "simulation exited with status $sim_rc"
	exit 1
fi

if grep -q "^STATUS: PASS$" <<< "$sim_out"; then
	exit 0
fi
exit 1
